// ==== Makefile ====
# Verilator build and run of the debug unit testbench

VERILATOR ?= verilator
TOP       ?= dbg_tb
LOG       ?= sim.log
FLAGS     ?= --assert

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP LOG FLAGS"

test:
	$(VERILATOR) --binary --timescale 1ns/100ps -f build.f --top-module $(TOP) \
		--Mdir $(OBJ_DIR) $(FLAGS)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+design
design/dbg_pkg.sv
design/dbg_cmd_rx.sv
design/dbg_sequencer.sv
design/dbg_byte_ser.sv
design/dbg_reply_tx.sv
design/dbg_top.sv
sim/dbg_tb.sv

// ==== design/dbg_byte_ser.sv ====
`timescale 1ns/100ps

module dbg_byte_ser
#(
	parameter type payload_t = dbg_pkg::word_t
)
(
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           load_valid_i,
	output logic           load_ready_o,
	input  payload_t       payload_i,
	output logic           out_valid_o,
	output dbg_pkg::byte_t out_data_o,
	input  logic           out_ready_i
);

	localparam int PW = $bits(payload_t);
	localparam int NB = PW / 8;
	localparam int CW = $clog2(NB + 1);

	logic [PW-1:0] shift_q;
	logic [CW-1:0] left_q; // Bytes still to send
	logic          load;
	logic          pop;

	assign load = load_valid_i && load_ready_o;
	assign pop  = out_valid_o && out_ready_i;

	assign load_ready_o = (left_q == '0);
	assign out_valid_o  = !load_ready_o;
	assign out_data_o   = shift_q[7:0]; // LSB first

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			left_q <= '0;
		else if (load)
			left_q <= CW'(NB);
		else if (pop)
			left_q <= left_q - 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shift_q <= payload_i;
		else if (pop)
			shift_q <= shift_q >> 8;
	end

	// Load request holds until the serializer takes it
	a_load_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		load_valid_i && !load_ready_o |=> load_valid_i);

endmodule

// ==== design/dbg_cmd_rx.sv ====
`timescale 1ns/100ps
`include "dbg_params.svh"

module dbg_cmd_rx
(
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           rx_valid_i,
	input  dbg_pkg::byte_t rx_data_i,
	output logic           rx_ready_o,
	output logic           cmd_valid_o,
	output dbg_pkg::cmd_t  cmd_o,
	input  logic           cmd_ready_i
);

	logic          valid_q;
	dbg_pkg::cmd_t cmd_q;
	dbg_pkg::cmd_t cmd_d;
	logic          take;

	// Byte decode
	always_comb
	begin
		case (rx_data_i)
			`DBG_CH_STEP: cmd_d = dbg_pkg::CMD_STEP;
			`DBG_CH_CONT: cmd_d = dbg_pkg::CMD_CONT;
			`DBG_CH_RST:  cmd_d = dbg_pkg::CMD_RST;
			default:      cmd_d = dbg_pkg::CMD_BAD;
		endcase
	end

	assign take        = rx_valid_i && rx_ready_o;
	assign rx_ready_o  = !valid_q; // Link stalls while a command waits
	assign cmd_valid_o = valid_q;
	assign cmd_o       = cmd_q;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			valid_q <= 1'b0;
		else if (take)
			valid_q <= 1'b1;
		else if (cmd_ready_i)
			valid_q <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
			cmd_q <= cmd_d;
	end

	// Held command must not change before the sequencer takes it
	a_cmd_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o));

endmodule

// ==== design/dbg_params.svh ====
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

////////////////////
// Dump layout
////////////////////

`define DBG_SNAP_BYTES 148
`define DBG_MEM_WORDS 4
`define DBG_MEM_BASE 79 // First word read at BASE+1
`define DBG_ADDR_W 12

// Target timing in clk cycles
`define DBG_MEM_LAT 4
`define DBG_TGT_RST_CYCLES 3

////////////////////
// Link characters
////////////////////

`define DBG_CH_STEP 8'h50 // P
`define DBG_CH_CONT 8'h43 // C
`define DBG_CH_RST 8'h52  // R
`define DBG_CH_ERR 8'h45  // E
`define DBG_CH_FIN 8'h46  // F
`define DBG_CH_LF 8'h0a

`endif

// ==== design/dbg_pkg.sv ====
`include "dbg_params.svh"

package dbg_pkg;

	// Link and memory data
	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [`DBG_ADDR_W-1:0] addr_t;

	// Register and control state of the target, byte 0 goes out first
	typedef logic [`DBG_SNAP_BYTES*8-1:0] snap_t;

	// Decoded command byte
	typedef enum logic [1:0]
	{
		CMD_STEP,
		CMD_CONT,
		CMD_RST,
		CMD_BAD
	} cmd_t;

	// Two-byte trailer selector
	typedef enum logic [1:0]
	{
		TR_NONE,
		TR_ERR, // "E\n"
		TR_RST, // "R\n"
		TR_FIN  // "F\n"
	} trail_t;

endpackage

// ==== design/dbg_reply_tx.sv ====
`timescale 1ns/100ps
`include "dbg_params.svh"

module dbg_reply_tx
(
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            snap_valid_i,
	input  dbg_pkg::byte_t  snap_data_i,
	output logic            snap_ready_o,
	input  logic            word_valid_i,
	input  dbg_pkg::byte_t  word_data_i,
	output logic            word_ready_o,
	input  logic            trail_valid_i,
	input  dbg_pkg::trail_t trail_i,
	output logic            trail_ready_o,
	output logic            tx_valid_o,
	output dbg_pkg::byte_t  tx_data_o,
	input  logic            tx_ready_i
);

	dbg_pkg::trail_t tr_q;
	logic            tr_lf_q; // Letter out, newline next
	logic            tr_idle;
	logic            load_en;
	logic            src_valid;
	dbg_pkg::byte_t  src_data;
	dbg_pkg::byte_t  tr_letter;

	assign tr_idle = (tr_q == dbg_pkg::TR_NONE);
	assign load_en = !tx_valid_o || tx_ready_i;

	always_comb
	begin
		case (tr_q)
			dbg_pkg::TR_ERR: tr_letter = `DBG_CH_ERR;
			dbg_pkg::TR_RST: tr_letter = `DBG_CH_RST;
			default:         tr_letter = `DBG_CH_FIN;
		endcase
	end

	////////////////////
	// Source select
	////////////////////

	// A running trailer drains before the next reply starts
	always_comb
	begin
		src_valid = 1'b1;
		if (!tr_idle)
			src_data = tr_lf_q ? dbg_pkg::byte_t'(`DBG_CH_LF) : tr_letter;
		else if (snap_valid_i)
			src_data = snap_data_i;
		else
		begin
			src_valid = word_valid_i;
			src_data  = word_data_i;
		end
	end

	assign snap_ready_o  = load_en && tr_idle;
	assign word_ready_o  = load_en && tr_idle && !snap_valid_i;
	assign trail_ready_o = tr_idle && !snap_valid_i && !word_valid_i && !tx_valid_o;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			tr_q    <= dbg_pkg::TR_NONE;
			tr_lf_q <= 1'b0;
		end
		else if (trail_valid_i && trail_ready_o)
		begin
			tr_q    <= trail_i;
			tr_lf_q <= 1'b0;
		end
		else if (load_en && !tr_idle)
		begin
			if (tr_lf_q)
				tr_q <= dbg_pkg::TR_NONE;
			tr_lf_q <= !tr_lf_q;
		end
	end

	// Output stage
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			tx_valid_o <= 1'b0;
		else if (load_en)
			tx_valid_o <= src_valid;
	end

	always_ff @(posedge clk)
	begin
		if (load_en && src_valid)
			tx_data_o <= src_data;
	end

	a_tx_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o));

endmodule

// ==== design/dbg_sequencer.sv ====
`timescale 1ns/100ps
`include "dbg_params.svh"

module dbg_sequencer
(
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            cmd_valid_i,
	input  dbg_pkg::cmd_t   cmd_i,
	output logic            cmd_ready_o,
	output logic            tgt_rst_o,
	output logic            tgt_step_o,
	output logic            tgt_run_o,
	input  logic            tgt_done_i,
	output logic            mem_rd_o,
	output dbg_pkg::addr_t  mem_addr_o,
	output logic            snap_load_o,
	input  logic            snap_load_ready_i,
	output logic            word_load_o,
	input  logic            word_load_ready_i,
	output logic            trail_valid_o,
	output dbg_pkg::trail_t trail_o,
	input  logic            trail_ready_i
);

	localparam int WIDX_W = $clog2(`DBG_MEM_WORDS + 1);

	typedef enum logic [3:0]
	{
		S_IDLE,
		S_STEP,
		S_RUN,
		S_SNAP,
		S_RD,
		S_WAIT,
		S_WLOAD,
		S_TRAIL,
		S_RSTH,
		S_DONE
	} state_t;

	state_t          state_q;
	dbg_pkg::trail_t trail_q;
	dbg_pkg::addr_t  addr_q;
	logic [WIDX_W-1:0] widx_q;
	logic [7:0]      cnt_q;   // Read latency and reset hold
	logic            rd_pend_q;

	////////////////////
	// Command FSM
	////////////////////

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= S_IDLE;
			trail_q <= dbg_pkg::TR_NONE;
			addr_q  <= '0;
			widx_q  <= '0;
			cnt_q   <= '0;
		end
		else
		begin
			case (state_q)
				S_IDLE:
				begin
					addr_q <= dbg_pkg::addr_t'(`DBG_MEM_BASE + 1);
					widx_q <= '0;
					if (cmd_valid_i)
					begin
						case (cmd_i)
							dbg_pkg::CMD_STEP: state_q <= S_STEP;
							dbg_pkg::CMD_CONT: state_q <= S_RUN;
							dbg_pkg::CMD_RST:
							begin
								trail_q <= dbg_pkg::TR_RST;
								state_q <= S_TRAIL;
							end
							default:
							begin
								trail_q <= dbg_pkg::TR_ERR;
								state_q <= S_TRAIL;
							end
						endcase
					end
				end
				S_STEP: state_q <= S_SNAP;
				S_RUN:
				begin
					if (tgt_done_i)
						state_q <= S_SNAP;
				end
				S_SNAP:
				begin
					if (snap_load_ready_i)
						state_q <= S_RD;
				end
				S_RD:
				begin
					cnt_q <= '0;
					if (word_load_ready_i)
						state_q <= S_WAIT;
				end
				S_WAIT:
				begin
					if (cnt_q == 8'(`DBG_MEM_LAT - 1))
						state_q <= S_WLOAD; // rdata valid from here on
					else
						cnt_q <= cnt_q + 8'd1;
				end
				S_WLOAD:
				begin
					if (word_load_ready_i)
					begin
						widx_q <= widx_q + 1'b1;
						addr_q <= addr_q + 1'b1;
						if (widx_q == WIDX_W'(`DBG_MEM_WORDS - 1))
						begin
							trail_q <= dbg_pkg::TR_FIN;
							state_q <= S_TRAIL;
						end
						else
							state_q <= S_RD;
					end
				end
				S_TRAIL:
				begin
					cnt_q <= '0;
					if (trail_ready_i)
						state_q <= (trail_q == dbg_pkg::TR_RST) ? S_RSTH : S_DONE;
				end
				S_RSTH:
				begin
					if (cnt_q == 8'(`DBG_TGT_RST_CYCLES - 1))
						state_q <= S_DONE;
					else
						cnt_q <= cnt_q + 8'd1;
				end
				// Trailer ready again once its newline left the link
				S_DONE:
				begin
					if (trail_ready_i)
						state_q <= S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	assign cmd_ready_o   = (state_q == S_IDLE);
	assign tgt_step_o    = (state_q == S_STEP);
	assign tgt_run_o     = (state_q == S_RUN);
	assign tgt_rst_o     = (state_q == S_RSTH);
	assign snap_load_o   = (state_q == S_SNAP);
	assign mem_rd_o      = (state_q == S_RD) && word_load_ready_i;
	assign mem_addr_o    = addr_q;
	assign word_load_o   = (state_q == S_WLOAD);
	assign trail_valid_o = (state_q == S_TRAIL);
	assign trail_o       = trail_q;

	// Read in flight until its word reaches the serializer
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			rd_pend_q <= 1'b0;
		else if (mem_rd_o)
			rd_pend_q <= 1'b1;
		else if (word_load_o && word_load_ready_i)
			rd_pend_q <= 1'b0;
	end

	a_step_run: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(tgt_step_o && tgt_run_o));

	a_one_read: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_rd_o |-> !rd_pend_q);

endmodule

// ==== design/dbg_top.sv ====
`timescale 1ns/100ps

module dbg_top
(
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           rx_valid_i,
	input  dbg_pkg::byte_t rx_data_i,
	output logic           rx_ready_o,
	output logic           tx_valid_o,
	output dbg_pkg::byte_t tx_data_o,
	input  logic           tx_ready_i,
	output logic           tgt_rst_o,
	output logic           tgt_step_o,
	output logic           tgt_run_o,
	input  logic           tgt_done_i,
	input  dbg_pkg::snap_t tgt_snap_i,
	output logic           mem_rd_o,
	output dbg_pkg::addr_t mem_addr_o,
	input  dbg_pkg::word_t mem_rdata_i
);

	logic            cmd_valid;
	dbg_pkg::cmd_t   cmd;
	logic            cmd_ready;
	logic            snap_load;
	logic            snap_load_ready;
	logic            word_load;
	logic            word_load_ready;
	logic            snap_valid;
	dbg_pkg::byte_t  snap_data;
	logic            snap_ready;
	logic            word_valid;
	dbg_pkg::byte_t  word_data;
	logic            word_ready;
	logic            trail_valid;
	dbg_pkg::trail_t trail;
	logic            trail_ready;

	dbg_cmd_rx cmd_rx (.clk(clk), .arst_n_i(arst_n_i), .rx_valid_i(rx_valid_i),
		.rx_data_i(rx_data_i), .rx_ready_o(rx_ready_o), .cmd_valid_o(cmd_valid),
		.cmd_o(cmd), .cmd_ready_i(cmd_ready));

	dbg_sequencer seq (.clk(clk), .arst_n_i(arst_n_i), .cmd_valid_i(cmd_valid),
		.cmd_i(cmd), .cmd_ready_o(cmd_ready), .tgt_rst_o(tgt_rst_o),
		.tgt_step_o(tgt_step_o), .tgt_run_o(tgt_run_o), .tgt_done_i(tgt_done_i),
		.mem_rd_o(mem_rd_o), .mem_addr_o(mem_addr_o), .snap_load_o(snap_load),
		.snap_load_ready_i(snap_load_ready), .word_load_o(word_load),
		.word_load_ready_i(word_load_ready), .trail_valid_o(trail_valid),
		.trail_o(trail), .trail_ready_i(trail_ready));

	// Snapshot and memory words share one serializer design
	dbg_byte_ser #(.payload_t(dbg_pkg::snap_t)) snap_ser (.clk(clk), .arst_n_i(arst_n_i),
		.load_valid_i(snap_load), .load_ready_o(snap_load_ready), .payload_i(tgt_snap_i),
		.out_valid_o(snap_valid), .out_data_o(snap_data), .out_ready_i(snap_ready));

	dbg_byte_ser #(.payload_t(dbg_pkg::word_t)) word_ser (.clk(clk), .arst_n_i(arst_n_i),
		.load_valid_i(word_load), .load_ready_o(word_load_ready), .payload_i(mem_rdata_i),
		.out_valid_o(word_valid), .out_data_o(word_data), .out_ready_i(word_ready));

	dbg_reply_tx reply_tx (.clk(clk), .arst_n_i(arst_n_i), .snap_valid_i(snap_valid),
		.snap_data_i(snap_data), .snap_ready_o(snap_ready), .word_valid_i(word_valid),
		.word_data_i(word_data), .word_ready_o(word_ready), .trail_valid_i(trail_valid),
		.trail_i(trail), .trail_ready_o(trail_ready), .tx_valid_o(tx_valid_o),
		.tx_data_o(tx_data_o), .tx_ready_i(tx_ready_i));

endmodule

// ==== sim/dbg_tb.sv ====
`timescale 1ns/100ps
`include "dbg_params.svh"

module dbg_tb;

	localparam int N_CMDS      = 24;
	localparam int REPLY_MAX   = `DBG_SNAP_BYTES + 4 * `DBG_MEM_WORDS + 2;
	localparam int BP_FACTOR   = 4;
	localparam int CMD_SLACK   = 200; // Run length, memory latency, reset hold
	localparam int PERIOD      = 4;
	localparam int WATCHDOG_NS = N_CMDS * (REPLY_MAX * BP_FACTOR + CMD_SLACK) * PERIOD;
	localparam logic [31:0] SEED = 32'h9c1b5054;

	logic           clk;
	logic           arst_n_i;
	logic           rx_valid_i;
	dbg_pkg::byte_t rx_data_i;
	logic           rx_ready_o;
	logic           tx_valid_o;
	dbg_pkg::byte_t tx_data_o;
	logic           tx_ready_i;
	logic           tgt_rst_o;
	logic           tgt_step_o;
	logic           tgt_run_o;
	logic           tgt_done_i;
	dbg_pkg::snap_t tgt_snap_i;
	logic           mem_rd_o;
	dbg_pkg::addr_t mem_addr_o;
	dbg_pkg::word_t mem_rdata_i;

	dbg_pkg::byte_t exp_q[$];
	logic [31:0]    tgt_rng;
	logic [31:0]    stim_rng;
	logic           bp_on;
	int unsigned    ev_cnt;   // Steps and runs since the last target reset
	int unsigned    pred_ev;
	int unsigned    run_left;
	logic           run_busy;
	logic           step_prev;
	logic           rst_prev;
	int unsigned    rst_len;
	logic [`DBG_MEM_LAT:0] rd_pipe;
	dbg_pkg::addr_t addr_pipe [`DBG_MEM_LAT+1];
	int unsigned    steps_seen, runs_seen, rsts_seen, reads_seen;
	int unsigned    n_step, n_cont, n_rst;
	int unsigned    n_tx;

	dbg_top dut0 (.clk(clk), .arst_n_i(arst_n_i), .rx_valid_i(rx_valid_i),
		.rx_data_i(rx_data_i), .rx_ready_o(rx_ready_o), .tx_valid_o(tx_valid_o),
		.tx_data_o(tx_data_o), .tx_ready_i(tx_ready_i), .tgt_rst_o(tgt_rst_o),
		.tgt_step_o(tgt_step_o), .tgt_run_o(tgt_run_o), .tgt_done_i(tgt_done_i),
		.tgt_snap_i(tgt_snap_i), .mem_rd_o(mem_rd_o), .mem_addr_o(mem_addr_o),
		.mem_rdata_i(mem_rdata_i));

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Counter in the low word, pseudo random registers above
	function automatic dbg_pkg::snap_t snap_image(input int unsigned n);
		dbg_pkg::snap_t s;
		logic [31:0]    x;
		x = SEED + n;
		s = '0;
		s[31:0] = n;
		for (int i = 1; i < `DBG_SNAP_BYTES / 4; i++)
		begin
			x = xorshift32(x);
			s[i*32 +: 32] = x;
		end
		return s;
	endfunction

	function automatic dbg_pkg::word_t mem_word(input dbg_pkg::addr_t a);
		return (32'(a) * 32'h00010001) ^ 32'hc3a50f1e;
	endfunction

	////////////////////
	// Reference reply
	////////////////////

	function automatic void expect_reply(input dbg_pkg::byte_t code, input int unsigned ev);
		dbg_pkg::snap_t s;
		dbg_pkg::word_t w;
		if (code == `DBG_CH_STEP || code == `DBG_CH_CONT)
		begin
			s = snap_image(ev);
			for (int i = 0; i < `DBG_SNAP_BYTES; i++)
				exp_q.push_back(s[i*8 +: 8]);
			for (int k = 0; k < `DBG_MEM_WORDS; k++)
			begin
				w = mem_word(dbg_pkg::addr_t'(`DBG_MEM_BASE + 1 + k));
				for (int j = 0; j < 4; j++)
					exp_q.push_back(w[j*8 +: 8]);
			end
			exp_q.push_back(`DBG_CH_FIN);
		end
		else if (code == `DBG_CH_RST)
			exp_q.push_back(`DBG_CH_RST);
		else
			exp_q.push_back(`DBG_CH_ERR);
		exp_q.push_back(`DBG_CH_LF);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t ns: %s expected %h, got %h",
				$time, what, exp, got));
	endtask

	function automatic dbg_pkg::byte_t pick_cmd();
		stim_rng = xorshift32(stim_rng);
		case (stim_rng[1:0])
			2'd0: return `DBG_CH_STEP;
			2'd1: return `DBG_CH_CONT;
			2'd2: return `DBG_CH_RST;
			default: return stim_rng[15:8]; // Mostly unknown codes
		endcase
	endfunction

	task automatic send_cmd(input dbg_pkg::byte_t code);
		int unsigned gap;
		stim_rng = xorshift32(stim_rng);
		gap = bp_on ? 32'(stim_rng[2:0]) : 0;
		repeat (gap) @(negedge clk);
		if (code == `DBG_CH_STEP || code == `DBG_CH_CONT)
			pred_ev++;
		expect_reply(code, pred_ev);
		if (code == `DBG_CH_STEP)
			n_step++;
		else if (code == `DBG_CH_CONT)
			n_cont++;
		else if (code == `DBG_CH_RST)
		begin
			n_rst++;
			pred_ev = 0;
		end
		rx_valid_i = 1'b1;
		rx_data_i  = code;
		@(posedge clk);
		while (!rx_ready_o)
			@(posedge clk);
		@(negedge clk);
		rx_valid_i = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0 || tgt_rst_o)
			@(negedge clk);
		repeat (8) @(negedge clk);
	endtask

	////////////////////
	// Target model
	////////////////////

	always @(negedge clk)
	begin
		if (arst_n_i === 1'b1)
		begin
			tgt_rng = xorshift32(tgt_rng);
			tx_ready_i = bp_on ? (tgt_rng[2:0] < 3'd5) : 1'b1;

			if (tgt_step_o)
			begin
				check_value("step pulse high on consecutive cycles", 32'(step_prev), 0);
				steps_seen++;
				ev_cnt++;
				tgt_snap_i = snap_image(ev_cnt);
			end
			step_prev = tgt_step_o;

			if (tgt_run_o && !tgt_done_i)
			begin
				if (!run_busy)
				begin
					run_busy = 1'b1;
					run_left = 32'(tgt_rng[6:3]);
				end
				if (run_left == 0)
				begin
					tgt_done_i = 1'b1;
					runs_seen++;
					ev_cnt++;
					tgt_snap_i = snap_image(ev_cnt);
				end
				else
					run_left--;
			end
			else if (!tgt_run_o)
			begin
				if (run_busy && !tgt_done_i)
					abort_run("Run request dropped before the target signalled done");
				tgt_done_i = 1'b0;
				run_busy   = 1'b0;
			end

			// Read pipeline, data held until the next request
			for (int i = `DBG_MEM_LAT; i > 0; i--)
			begin
				rd_pipe[i]   = rd_pipe[i-1];
				addr_pipe[i] = addr_pipe[i-1];
			end
			rd_pipe[0]   = mem_rd_o;
			addr_pipe[0] = mem_addr_o;
			if (mem_rd_o)
			begin
				reads_seen++;
				mem_rdata_i = 'x;
			end
			if (rd_pipe[`DBG_MEM_LAT])
				mem_rdata_i = mem_word(addr_pipe[`DBG_MEM_LAT]);

			if (tgt_rst_o)
				rst_len++;
			else if (rst_prev)
			begin
				check_value("target reset length", rst_len, `DBG_TGT_RST_CYCLES);
				rsts_seen++;
				rst_len    = 0;
				ev_cnt     = 0;
				tgt_snap_i = snap_image(0);
			end
			rst_prev = tgt_rst_o;
		end
	end

	// Reply compare, one expected byte per tx transfer
	always @(posedge clk)
	begin
		if (arst_n_i === 1'b1 && tx_valid_o && tx_ready_i)
		begin
			n_tx++;
			if (exp_q.size() == 0)
				abort_run($sformatf("Reply byte %h was sent with no reply pending", tx_data_o));
			else
				check_value($sformatf("tx byte %0d", n_tx), 32'(tx_data_o),
					32'(exp_q.pop_front()));
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("Timeout: the DUT did not finish all replies in time");
	end

	initial
	begin
		clk = 1'b0;
		arst_n_i = 1'b0;
		rx_valid_i = 1'b0;
		rx_data_i = 8'h00;
		tx_ready_i = 1'b1;
		tgt_done_i = 1'b0;
		tgt_snap_i = snap_image(0);
		mem_rdata_i = '0;
		tgt_rng = SEED;
		stim_rng = ~SEED;
		bp_on = 1'b0;
		ev_cnt = 0;
		pred_ev = 0;
		run_left = 0;
		run_busy = 1'b0;
		step_prev = 1'b0;
		rst_prev = 1'b0;
		rst_len = 0;
		rd_pipe = '0;
		for (int i = 0; i <= `DBG_MEM_LAT; i++)
			addr_pipe[i] = '0;
		steps_seen = 0;
		runs_seen = 0;
		rsts_seen = 0;
		reads_seen = 0;
		n_step = 0;
		n_cont = 0;
		n_rst = 0;
		n_tx = 0;

		repeat (2) @(negedge clk);
		arst_n_i = 1'b1;
		check_value("tx_valid_o after reset", 32'(tx_valid_o), 0);
		check_value("tgt_rst_o after reset", 32'(tgt_rst_o), 0);
		check_value("tgt_step_o after reset", 32'(tgt_step_o), 0);
		check_value("tgt_run_o after reset", 32'(tgt_run_o), 0);
		check_value("mem_rd_o after reset", 32'(mem_rd_o), 0);
		check_value("rx_ready_o after reset", 32'(rx_ready_o), 1);

		// Directed commands at full link speed
		send_cmd(`DBG_CH_STEP);
		send_cmd(`DBG_CH_CONT);
		send_cmd(8'h5a);
		send_cmd(`DBG_CH_RST);
		send_cmd(`DBG_CH_STEP);
		wait_idle();
		check_value("step pulses", steps_seen, 2);
		check_value("completed runs", runs_seen, 1);
		check_value("target resets", rsts_seen, 1);

		// Mixed commands with link gaps
		bp_on = 1'b1;
		for (int i = 5; i < N_CMDS; i++)
			send_cmd(pick_cmd());
		wait_idle();
		check_value("step pulses", steps_seen, n_step);
		check_value("completed runs", runs_seen, n_cont);
		check_value("target resets", rsts_seen, n_rst);
		check_value("memory reads", reads_seen, `DBG_MEM_WORDS * (n_step + n_cont));

		$display("STATUS: PASS");
		$finish;
	end

endmodule
